// ==== Bender.yml ====
package:
  name: zx_glue

sources:
  - files:
      - verilog/zx_bus_pkg.sv
      - verilog/zx_audio_pkg.sv
      - verilog/io_decode.sv
      - verilog/input_ports.sv
      - verilog/sound_ports.sv
      - verilog/ext_int_latch.sv
      - verilog/zx_glue_top.sv
  - target: test
    files:
      - testbench/zx_glue_checker.sv
      - testbench/zx_glue_tb.sv

// ==== testbench/zx_glue_checker.sv ====
`timescale 1ns/1ps

module zx_glue_checker (
  input  logic        clk_28mhz,
  input  logic        rst,
  input  logic [15:0] cpu_a,
  input  logic [7:0]  cpu_do,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [7:0]  cpu_di,
  input  logic        int_n,
  input  logic [4:0]  keyboard_data,
  input  logic [7:0]  joy_data,
  input  logic [7:0]  mouse_data,
  input  logic [7:0]  keyboard_addr,
  input  logic [2:0]  mouse_addr,
  input  logic        tape_in,
  input  logic [2:0]  border,
  input  logic        tape_out,
  input  logic [15:0] audio_out,
  input  logic        ftint,
  output int          error_count,
  output int          check_count
);

  localparam logic [7:0] FE_PORT    = 8'hFE;
  localparam logic [7:0] JOY_PORT   = 8'h1F;
  localparam logic [7:0] COVOX_PORT = 8'hFB;
  localparam logic [7:0] MOUSE_PORT = 8'hDF;

  // model of the write side
  logic [4:0] fe_model;
  logic [7:0] covox_model;
  logic [7:0] port;
  logic       wr_cyc;
  logic       rd_cyc;
  logic       ack_cyc;
  logic       rst_prev;
  logic       ftint_prev;
  logic       int_exp;
  int         bus_cnt;
  int         fall_age;

  function automatic logic [7:0] expected_read(input logic [7:0] p, input logic ack,
                                               input logic rd,
                                               input logic [4:0] kb, input logic tape,
                                               input logic [7:0] joy, input logic [7:0] ms);
    if (ack) begin
      expected_read = 8'hFD;
    end else if (!rd) begin
      expected_read = 8'hFF;
    end else if (p == FE_PORT) begin
      expected_read = {1'b1, tape, 1'b1, kb};
    end else if (p == JOY_PORT) begin
      expected_read = joy;
    end else if (p == MOUSE_PORT) begin
      expected_read = ms;
    end else begin
      expected_read = 8'hFF;
    end
  endfunction

  function automatic logic [15:0] expected_audio(input logic [7:0] smp, input logic spk,
                                                 input logic tape);
    expected_audio = {3'b000, smp, 5'b00000};
    if (spk) begin
      expected_audio = expected_audio + 16'h4000;
    end
    if (tape) begin
      expected_audio = expected_audio + 16'h1000;
    end
  endfunction

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    check_count = check_count + 1;
    if (exp !== act) begin
      error_count = error_count + 1;
      $display("Error %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    wr_cyc      = 1'b0;
    rd_cyc      = 1'b0;
    ack_cyc     = 1'b0;
  end

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk_28mhz) begin
    if (rst) begin
      fe_model    = '0;
      covox_model = '0;
      int_exp     = 1'b1;
      ftint_prev  = 1'b1;
      bus_cnt     = 0;
      fall_age    = 0;
    end else begin
      if (rst_prev) begin
        compare("cpu_di", 16'h00FF, cpu_di);
        compare("border", 16'h0000, border);
        compare("tape_out", 16'h0000, tape_out);
        compare("audio_out", 16'h0000, audio_out);
      end
      // int_n drops 3 clocks after ftint falls
      if (ftint_prev && !ftint) begin
        fall_age = 1;
      end else if (fall_age != 0) begin
        fall_age = fall_age + 1;
      end
      if (fall_age == 4) begin
        int_exp  = 1'b0;
        fall_age = 0;
      end
      ftint_prev = ftint;

      bus_cnt = iorq_n ? 0 : bus_cnt + 1;
      if (bus_cnt == 1) begin
        port    = cpu_a[7:0];
        wr_cyc  = m1_n && !wr_n;
        rd_cyc  = m1_n && !rd_n;
        ack_cyc = !m1_n;
        if (wr_cyc && port == FE_PORT) begin
          fe_model = cpu_do[4:0];
        end
        if (wr_cyc && port == COVOX_PORT) begin
          covox_model = cpu_do;
        end
      end
      if (bus_cnt == 3 && ack_cyc) begin
        int_exp = 1'b1;
      end
      if (bus_cnt == 4 && wr_cyc) begin
        compare("border", fe_model[2:0], border);
        compare("tape_out", fe_model[3], tape_out);
        compare("audio_out", expected_audio(covox_model, fe_model[4], tape_in), audio_out);
      end
      if (bus_cnt == 5) begin
        compare("cpu_di", expected_read(port, ack_cyc, rd_cyc, keyboard_data, tape_in,
                                        joy_data, mouse_data), cpu_di);
        if (rd_cyc && port == MOUSE_PORT) begin
          compare("mouse_addr", cpu_a[10:8], mouse_addr);
        end
      end
      compare("keyboard_addr", cpu_a[15:8], keyboard_addr);
      compare("int_n", int_exp, int_n);
    end
    rst_prev = rst;
  end

endmodule

// ==== testbench/zx_glue_tb.sv ====
`timescale 1ns/1ps

module zx_glue_tb;

  localparam int N_FE_WR    = 12;
  localparam int N_OTHER_WR = 6;
  localparam int N_FB_WR    = 12;
  // four reads per loop pass (FE, 1F, DF, other)
  localparam int N_READS    = 8;
  localparam int N_ACK      = 3;
  localparam int N_BUS      = N_FE_WR + N_OTHER_WR + N_FB_WR + 4 * N_READS + N_ACK;
  localparam int TIMEOUT_CYCLES = 8 * N_BUS + 200;

  logic        clk_28mhz = 1'b0;
  logic        rst;
  logic [15:0] cpu_a;
  logic [7:0]  cpu_do;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [7:0]  cpu_di;
  logic        int_n;
  logic [4:0]  keyboard_data;
  logic [7:0]  joy_data;
  logic [7:0]  mouse_data;
  logic [7:0]  keyboard_addr;
  logic [2:0]  mouse_addr;
  logic        tape_in;
  logic [2:0]  border;
  logic        tape_out;
  logic [15:0] audio_out;
  logic        ftint;
  int          error_count;
  int          check_count;

  logic [31:0] lfsr = 32'd67621;
  int          cycle_cnt = 0;
  logic [31:0] r;
  logic [7:0]  lo;
  int          i;

  always #2 clk_28mhz = ~clk_28mhz;

  zx_glue_top UUT (.*);

  zx_glue_checker u_checker (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h80200003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic drive_peripherals();
    logic [31:0] v;
    take_bits(22, v);
    keyboard_data <= v[4:0];
    joy_data      <= v[12:5];
    mouse_data    <= v[20:13];
    tape_in       <= v[21];
  endtask

  // iorq_n low for 6 clocks, then 2 idle clocks
  task automatic end_cycle();
    repeat (6) @(posedge clk_28mhz);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wr_n   <= 1'b1;
    m1_n   <= 1'b1;
    @(posedge clk_28mhz);
  endtask

  task automatic io_write(input logic [15:0] a, input logic [7:0] d);
    @(posedge clk_28mhz);
    drive_peripherals();
    cpu_a  <= a;
    cpu_do <= d;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    end_cycle();
  endtask

  task automatic io_read(input logic [15:0] a);
    @(posedge clk_28mhz);
    drive_peripherals();
    cpu_a  <= a;
    iorq_n <= 1'b0;
    rd_n   <= 1'b0;
    end_cycle();
  endtask

  task automatic int_ack();
    @(posedge clk_28mhz);
    iorq_n <= 1'b0;
    m1_n   <= 1'b0;
    end_cycle();
  endtask

  task automatic set_ftint(input logic level);
    @(posedge clk_28mhz);
    ftint <= level;
  endtask

  always @(posedge clk_28mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    rst           = 1'b1;
    cpu_a         = '0;
    cpu_do        = '0;
    iorq_n        = 1'b1;
    rd_n          = 1'b1;
    wr_n          = 1'b1;
    m1_n          = 1'b1;
    keyboard_data = 5'h1F;
    joy_data      = '0;
    mouse_data    = '0;
    tape_in       = 1'b0;
    ftint         = 1'b1;
    repeat (16) @(posedge clk_28mhz);
    rst <= 1'b0;
    repeat (4) @(posedge clk_28mhz);

    for (i = 0; i < N_FE_WR; i++) begin
      take_bits(16, r);
      io_write({r[15:8], 8'hFE}, r[7:0]);
    end
    // writes elsewhere must not touch FE or the sample
    for (i = 0; i < N_OTHER_WR; i++) begin
      take_bits(24, r);
      lo = r[7:0];
      if (lo == 8'hFE || lo == 8'hFB) begin
        lo = 8'h3F;
      end
      io_write({r[23:16], lo}, r[15:8]);
    end
    for (i = 0; i < N_FB_WR; i++) begin
      take_bits(16, r);
      io_write({r[15:8], 8'hFB}, r[7:0]);
    end

    for (i = 0; i < N_READS; i++) begin
      take_bits(32, r);
      io_read({r[7:0], 8'hFE});
      io_read({r[15:8], 8'h1F});
      io_read({r[23:16], 8'hDF});
      lo = r[31:24];
      if (lo == 8'hFE || lo == 8'h1F || lo == 8'hDF) begin
        lo = 8'h3F;
      end
      io_read({r[15:8], lo});
    end

    // falling step, acknowledge, rising step, steady low level
    set_ftint(1'b0);
    repeat (8) @(posedge clk_28mhz);
    int_ack();
    repeat (8) @(posedge clk_28mhz);
    set_ftint(1'b1);
    repeat (8) @(posedge clk_28mhz);
    int_ack();
    set_ftint(1'b0);
    repeat (6) @(posedge clk_28mhz);
    int_ack();
    repeat (8) @(posedge clk_28mhz);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/ext_int_latch.sv ====
`timescale 1ns/1ps

module ext_int_latch (
  input  logic clk_28mhz,
  input  logic rst,
  input  logic ftint,
  input  logic intack,
  output logic int_n
);
  import zx_bus_pkg::*;

  logic ftint_s1;
  logic ftint_s2;
  logic ftint_d;
  logic fall;
  logic pending;

  // ftint is asynchronous to clk_28mhz
  // sync stages idle high so reset gives no false edge
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ftint_s1 <= 1'b1;
      ftint_s2 <= 1'b1;
      ftint_d  <= 1'b1;
    end else begin
      ftint_s1 <= ftint;
      ftint_s2 <= ftint_s1;
      ftint_d  <= ftint_s2;
    end
  end

  assign fall = ftint_d && !ftint_s2;

  // acknowledge beats a new edge in the same clock
  always_ff @(posedge clk_28mhz) begin
    if (rst || intack) begin
      pending <= 1'b0;
    end else if (fall) begin
      pending <= 1'b1;
    end
  end

  assign int_n = !pending;

endmodule

// ==== verilog/input_ports.sv ====
`timescale 1ns/1ps

module input_ports (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  zx_bus_pkg::rd_src_t rd_src,
  input  zx_bus_pkg::addr_t   cpu_a,
  input  logic [4:0]          keyboard_data,
  input  zx_bus_pkg::data_t   joy_data,
  input  zx_bus_pkg::data_t   mouse_data,
  input  logic                tape_in,
  output zx_bus_pkg::data_t   cpu_di,
  output zx_bus_pkg::data_t   keyboard_addr,
  output logic [2:0]          mouse_addr
);
  import zx_bus_pkg::*;

  data_t fe_byte;
  data_t rd_byte;

  // half-row select comes straight from the upper address byte
  assign keyboard_addr = cpu_a[15:8];

  // mouse register select (x, y, buttons)
  assign mouse_addr = cpu_a[10:8];

  // port FE read: bits 7 and 5 float high
  assign fe_byte = {1'b1, tape_in, 1'b1, keyboard_data};

  always_comb begin
    case (rd_src)
      RD_FE:       rd_byte = fe_byte;
      RD_KEMPSTON: rd_byte = joy_data;
      RD_MOUSE:    rd_byte = mouse_data;
      RD_VECTOR:   rd_byte = IM2_VECTOR;
      default:     rd_byte = IDLE_BYTE;
    endcase
  end

  // registered so the cpu sees a stable byte for the rest of the cycle
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      cpu_di <= IDLE_BYTE;
    end else begin
      cpu_di <= rd_byte;
    end
  end

endmodule

// ==== verilog/io_decode.sv ====
`timescale 1ns/1ps

module io_decode (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  zx_bus_pkg::addr_t   cpu_a,
  input  logic                iorq_n,
  input  logic                rd_n,
  input  logic                wr_n,
  input  logic                m1_n,
  output logic                fe_wr,
  output logic                covox_wr,
  output logic                intack,
  output zx_bus_pkg::rd_src_t rd_src
);
  import zx_bus_pkg::*;

  cyc_state_t state;
  port_lo_t   port_lo;
  logic       ack_cyc;
  logic       io_start;
  logic       io_write;

  assign port_lo = cpu_a[7:0];

  // first clock of an i/o or acknowledge cycle
  assign io_start = (state == CYC_IDLE) && !iorq_n;

  // m1_n low together with iorq_n marks an acknowledge, never a write
  assign io_write = io_start && m1_n && !wr_n;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      state    <= CYC_IDLE;
      ack_cyc  <= 1'b0;
      fe_wr    <= 1'b0;
      covox_wr <= 1'b0;
      intack   <= 1'b0;
    end else begin
      // strobes only fire on the idle to strobe step, so one per cycle
      fe_wr    <= io_write && (port_lo == PORT_FE);
      covox_wr <= io_write && (port_lo == PORT_COVOX);
      intack   <= io_start && !m1_n;

      case (state)
        CYC_IDLE: begin
          if (!iorq_n) begin
            state   <= CYC_STROBE;
            ack_cyc <= !m1_n;
          end
        end
        CYC_STROBE: begin
          state <= CYC_HOLD;
        end
        CYC_HOLD: begin
          // cpu may stretch the cycle as long as it likes
          if (iorq_n) begin
            state   <= CYC_IDLE;
            ack_cyc <= 1'b0;
          end
        end
        default: begin
          state   <= CYC_IDLE;
          ack_cyc <= 1'b0;
        end
      endcase
    end
  end

  // read source, valid from strobe through hold
  always_comb begin
    rd_src = RD_NONE;
    if (state != CYC_IDLE) begin
      if (ack_cyc) begin
        if (!iorq_n) begin
          rd_src = RD_VECTOR;
        end
      end else if (!rd_n) begin
        case (port_lo)
          PORT_FE:       rd_src = RD_FE;
          PORT_KEMPSTON: rd_src = RD_KEMPSTON;
          PORT_MOUSE:    rd_src = RD_MOUSE;
          default:       rd_src = RD_NONE;
        endcase
      end
    end
  end

endmodule

// ==== verilog/sound_ports.sv ====
`timescale 1ns/1ps

module sound_ports (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  input  zx_bus_pkg::data_t    cpu_do,
  input  logic                 fe_wr,
  input  logic                 covox_wr,
  input  logic                 tape_in,
  output logic [2:0]           border,
  output logic                 tape_out,
  output zx_audio_pkg::audio_t audio_out
);
  import zx_bus_pkg::*;
  import zx_audio_pkg::*;

  // port FE, only bits 4..0 are implemented
  logic [4:0] fe_reg;
  data_t      covox_smp;
  logic       speaker;
  audio_t     covox_lvl;
  audio_t     spk_lvl;
  audio_t     tape_lvl;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_reg    <= '0;
      covox_smp <= '0;
    end else begin
      if (fe_wr) begin
        fe_reg <= cpu_do[4:0];
      end
      if (covox_wr) begin
        covox_smp <= cpu_do;
      end
    end
  end

  assign border   = fe_reg[2:0];
  assign tape_out = fe_reg[3];
  assign speaker  = fe_reg[4];

  // mixer terms
  assign covox_lvl = audio_t'(covox_smp) << COVOX_SHIFT;
  assign spk_lvl   = speaker ? SPEAKER_LEVEL : '0;
  assign tape_lvl  = tape_in ? TAPE_LEVEL : '0;

  // one clock behind the register update
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out <= '0;
    end else begin
      audio_out <= covox_lvl + spk_lvl + tape_lvl;
    end
  end

endmodule

// ==== verilog/zx_audio_pkg.sv ====
package zx_audio_pkg;

  // mixed audio word sent to the dac side
  typedef logic [15:0] audio_t;

  // beeper contribution when port FE bit 4 is set
  localparam audio_t SPEAKER_LEVEL = 16'h4000;

  // tape input contribution, quieter than the beeper
  localparam audio_t TAPE_LEVEL = 16'h1000;

  // covox sample is unsigned 8 bit, scaled up before mixing
  // max is 0x1FE0 so the sum of all three never wraps
  localparam int COVOX_SHIFT = 5;

endpackage

// ==== verilog/zx_bus_pkg.sv ====
package zx_bus_pkg;

  // z80 bus widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // low address byte, the only part used for port decode
  typedef logic [7:0]  port_lo_t;

  // decoded i/o ports (low byte)
  localparam port_lo_t PORT_FE       = 8'hFE;
  localparam port_lo_t PORT_KEMPSTON = 8'h1F;
  localparam port_lo_t PORT_COVOX    = 8'hFB;
  localparam port_lo_t PORT_MOUSE    = 8'hDF;

  // fixed im2 vector put on the bus during interrupt acknowledge
  localparam data_t IM2_VECTOR = 8'hFD;

  // floating bus value
  localparam data_t IDLE_BYTE = 8'hFF;

  // who supplies the byte returned to the cpu
  typedef enum logic [2:0] {
    RD_NONE,
    RD_FE,
    RD_KEMPSTON,
    RD_MOUSE,
    RD_VECTOR
  } rd_src_t;

  // bus cycle tracker states
  // strobe lasts one clock, hold waits for iorq_n to go high
  typedef enum logic [1:0] {
    CYC_IDLE,
    CYC_STROBE,
    CYC_HOLD
  } cyc_state_t;

endpackage

// ==== verilog/zx_glue_top.sv ====
`timescale 1ns/1ps

module zx_glue_top (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  // z80 bus
  input  zx_bus_pkg::addr_t    cpu_a,
  input  zx_bus_pkg::data_t    cpu_do,
  input  logic                 iorq_n,
  input  logic                 rd_n,
  input  logic                 wr_n,
  input  logic                 m1_n,
  output zx_bus_pkg::data_t    cpu_di,
  output logic                 int_n,
  // keyboard, joystick and mouse
  input  logic [4:0]           keyboard_data,
  input  zx_bus_pkg::data_t    joy_data,
  input  zx_bus_pkg::data_t    mouse_data,
  output zx_bus_pkg::data_t    keyboard_addr,
  output logic [2:0]           mouse_addr,
  // tape, border and sound
  input  logic                 tape_in,
  output logic [2:0]           border,
  output logic                 tape_out,
  output zx_audio_pkg::audio_t audio_out,
  // external interrupt source
  input  logic                 ftint
);

  logic                fe_wr;
  logic                covox_wr;
  logic                intack;
  zx_bus_pkg::rd_src_t rd_src;

  io_decode u_io_decode (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cpu_a     (cpu_a),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .m1_n      (m1_n),
    .fe_wr     (fe_wr),
    .covox_wr  (covox_wr),
    .intack    (intack),
    .rd_src    (rd_src)
  );

  input_ports u_input_ports (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .rd_src        (rd_src),
    .cpu_a         (cpu_a),
    .keyboard_data (keyboard_data),
    .joy_data      (joy_data),
    .mouse_data    (mouse_data),
    .tape_in       (tape_in),
    .cpu_di        (cpu_di),
    .keyboard_addr (keyboard_addr),
    .mouse_addr    (mouse_addr)
  );

  sound_ports u_sound_ports (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cpu_do    (cpu_do),
    .fe_wr     (fe_wr),
    .covox_wr  (covox_wr),
    .tape_in   (tape_in),
    .border    (border),
    .tape_out  (tape_out),
    .audio_out (audio_out)
  );

  ext_int_latch u_ext_int_latch (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .ftint     (ftint),
    .intack    (intack),
    .int_n     (int_n)
  );

endmodule

// ==== zx_glue.f ====
verilog/zx_bus_pkg.sv
verilog/zx_audio_pkg.sv
verilog/io_decode.sv
verilog/input_ports.sv
verilog/sound_ports.sv
verilog/ext_int_latch.sv
verilog/zx_glue_top.sv
testbench/zx_glue_checker.sv
testbench/zx_glue_tb.sv
